/* Bender.yml */
package:
  name: ula

sources:
  - files:
      - rtl/ulaPkg.sv
      - rtl/beamIf.sv
      - rtl/beamCounter.sv
      - rtl/videoFetch.sv
      - rtl/pixelShifter.sv
      - rtl/colourEncoder.sv
      - rtl/cpuPort.sv
      - rtl/ulaTop.sv
  - target: test
    files:
      - dv/ulaTb.sv

/* all.f */
rtl/ulaPkg.sv
rtl/beamIf.sv
rtl/beamCounter.sv
rtl/videoFetch.sv
rtl/pixelShifter.sv
rtl/colourEncoder.sv
rtl/cpuPort.sv
rtl/ulaTop.sv
dv/ulaTb.sv

/* dv/ulaInput.txt */
// P addr data | W frame line hc addr data | R frame line hc addr issue2 ear kbd dout name
// X frame line col name | frame, line, hc and col are decimal, the rest is hex
P 0000 F0
P 1800 0A
P 0123 AA
P 1823 4C
P 080A 81
P 090A 7E
P 190A 39
P 0C94 AA
P 1994 0C
P 17FF 0F
P 1AFF 96
X 0 0 0 paper
X 0 0 4 paper
X 0 0 300 border
X 0 9 24 bright
X 0 9 25 bright
X 0 64 80 paper
X 0 64 81 paper
X 0 65 80 paper
X 0 65 81 paper
X 0 100 160 bright
X 0 100 161 bright
X 0 191 248 flash
X 0 191 252 flash
X 0 250 100 border
R 0 260 0 00FE 0 0 1F BF portRead
R 0 260 8 00FE 0 1 15 F5 portRead
R 0 260 16 00FE 1 0 0A AA portRead
R 0 260 24 00FF 0 0 1F FF portRead
R 0 260 32 7FFE 1 1 00 E0 portRead
W 1 260 0 00FE 0D
R 1 260 8 00FE 0 0 1F BF portRead
R 1 260 16 00FE 1 0 0F EF portRead
R 1 260 24 00FE 1 1 0F AF portRead
X 2 0 300 border
X 2 200 0 border
X 2 250 433 border
W 3 260 0 00FE 16
R 3 260 8 00FE 0 0 03 E3 portRead
R 3 260 16 00FE 1 1 03 A3 portRead
X 4 0 0 paper
X 4 191 300 border
X 16 191 248 flash
X 16 191 252 flash
X 16 250 100 border

/* dv/ulaTb.sv */
`timescale 1ns/1ps

module ulaTb;

   localparam int clockPeriod   = 100;
   localparam int lineCycles    = 448;
   localparam int frameRows     = 312;
   localparam int latency       = 14;
   localparam int flashRow      = 248;
   localparam int timeoutCycles = 18 * lineCycles * frameRows + 4 * lineCycles;
   localparam logic [31:0] lcgSeed = 32'h52d2_be1b;

   logic        clkregs;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        ear;
   logic [4:0]  kbd;
   logic        issue2Keyboard;
   logic        mic;
   logic        spk;
   logic [12:0] va;
   logic [7:0]  vramData;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;

   logic [7:0] vram [0:8191];
   logic [2:0] borderModel;
   logic       micModel;
   logic       spkModel;
   int         tbHc;
   int         tbVc;
   int         tbFrame;
   int         runCycles;
   int         checks;
   int         errors;

   ulaTop u_ulaTop (
      .clkregs        (clkregs),
      .rst_n          (rst_n),
      .a              (a),
      .iorq_n         (iorq_n),
      .rd_n           (rd_n),
      .wr_n           (wr_n),
      .din            (din),
      .dout           (dout),
      .ear            (ear),
      .kbd            (kbd),
      .issue2Keyboard (issue2Keyboard),
      .mic            (mic),
      .spk            (spk),
      .va             (va),
      .vramData       (vramData),
      .r              (r),
      .g              (g),
      .b              (b)
   );

   // VRAM answers without delay
   assign vramData = vram[va];

   initial begin
      clkregs = 1'b0;
      forever #(clockPeriod / 2) clkregs = ~clkregs;
   end

   // Own copy of the beam position, frames counted from reset release
   always @(posedge clkregs) begin
      if (!rst_n) begin
         tbHc    <= 0;
         tbVc    <= 0;
         tbFrame <= 0;
      end else if (tbHc == lineCycles - 1) begin
         tbHc <= 0;
         if (tbVc == frameRows - 1) begin
            tbVc    <= 0;
            tbFrame <= tbFrame + 1;
         end else begin
            tbVc <= tbVc + 1;
         end
      end else begin
         tbHc <= tbHc + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int beamPos(input int frame, input int line, input int hc);
      return (frame * frameRows + line) * lineCycles + hc;
   endfunction

   function automatic logic [2:0] intensity(input logic on, input logic bright);
      if (!on) return 3'b000;
      return bright ? 3'b111 : 3'b101;
   endfunction

   // IGRB expected at screen position (x, y) of a frame
   function automatic logic [3:0] expectedIgrb(input int frame, input int y, input int x);
      logic [7:0] row;
      logic [4:0] col;
      logic [7:0] pix;
      logic [7:0] attr;
      int         ticks;
      logic       pixelOn;
      logic [3:0] colour;
      if (y >= 192 || x >= 256) begin
         colour = {1'b0, borderModel};
      end else begin
         row  = y[7:0];
         col  = x[7:3];
         pix  = vram[{row[7:6], row[2:0], row[5:3], col}];
         attr = vram[{3'b110, row[7:3], col}];
         // Frame ticks so far, tick lands on flashRow
         ticks   = (y < flashRow) ? frame : frame + 1;
         pixelOn = pix[7 - x[2:0]] ^ (attr[7] & ticks[4]);
         colour  = pixelOn ? {attr[6], attr[2:0]} : {attr[6], attr[5:3]};
      end
      return colour;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic fillVram();
      logic [31:0] state;
      state = lcgSeed;
      for (int i = 0; i < 8192; i++) begin
         state   = lcgNext(state);
         vram[i] = state[31:24];
      end
   endtask

   // Returns on the falling edge of the cycle at the given beam position
   task automatic waitForBeam(input int frame, input int line, input int hc);
      int target;
      target = beamPos(frame, line, hc);
      if (beamPos(tbFrame, tbVc, tbHc) > target) begin
         errors++;
         $display("Record at frame %0d line %0d hc %0d comes after the beam passed it",
                  frame, line, hc);
      end else begin
         while (beamPos(tbFrame, tbVc, tbHc) < target) begin
            @(negedge clkregs);
         end
      end
   endtask

   task automatic portWrite(input logic [15:0] addr, input logic [7:0] data);
      a      = addr;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      @(negedge clkregs);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      a      = 16'hFFFF;
      if (!addr[0]) begin
         borderModel = data[2:0];
         micModel    = data[3];
         spkModel    = data[4];
      end
      // MIC and speaker follow the write at the edge just passed
      checks++;
      if (mic !== micModel || spk !== spkModel) begin
         errors++;
         $display("ERR portWrite: mic,spk expected %b,%b actual %b,%b",
                  micModel, spkModel, mic, spk);
      end
   endtask

   task automatic portRead(input logic [15:0] addr, input logic i2, input logic earIn,
                           input logic [4:0] kbdIn, input logic [7:0] expDout,
                           input logic [8*16-1:0] name);
      a              = addr;
      issue2Keyboard = i2;
      ear            = earIn;
      kbd            = kbdIn;
      iorq_n         = 1'b0;
      rd_n           = 1'b0;
      #(clockPeriod / 4);
      checks++;
      if (dout !== expDout) begin
         errors++;
         $display("ERR %0s: a=%h expected %02h actual %02h", name, addr, expDout, dout);
      end
      @(negedge clkregs);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      a      = 16'hFFFF;
   endtask

   task automatic checkPixel(input int frame, input int y, input int x,
                             input logic [8*16-1:0] name);
      logic [3:0] igrb;
      logic [8:0] expRgb;
      logic [8:0] actRgb;
      waitForBeam(frame, y, x + latency);
      igrb   = expectedIgrb(frame, y, x);
      // GGGRRRBBB
      expRgb = {intensity(igrb[2], igrb[3]), intensity(igrb[1], igrb[3]),
                intensity(igrb[0], igrb[3])};
      actRgb = {g, r, b};
      checks++;
      if (actRgb !== expRgb) begin
         errors++;
         $display("ERR %0s: frame %0d line %0d col %0d expected %03h actual %03h",
                  name, frame, y, x, expRgb, actRgb);
      end
   endtask

   task automatic runRecords(input int fd);
      logic [8*160-1:0] lineBuf;
      logic [8*8-1:0]   tag;
      logic [8*16-1:0]  name;
      int               n;
      int               f;
      int               l;
      int               h;
      logic [15:0]      addr;
      logic [7:0]       data;
      logic [7:0]       expDout;
      logic [4:0]       kbdIn;
      logic             i2;
      logic             earIn;
      while (!$feof(fd)) begin
         lineBuf = '0;
         n = $fgets(lineBuf, fd);
         n = $sscanf(lineBuf, "%s", tag);
         if (n < 1 || tag == "//") begin
            continue;
         end
         if (tag == "P") begin
            n = $sscanf(lineBuf, "%s %h %h", tag, addr, data);
            vram[addr[12:0]] = data;
         end else if (tag == "W") begin
            n = $sscanf(lineBuf, "%s %d %d %d %h %h", tag, f, l, h, addr, data);
            waitForBeam(f, l, h);
            portWrite(addr, data);
         end else if (tag == "R") begin
            n = $sscanf(lineBuf, "%s %d %d %d %h %h %h %h %h %s", tag, f, l, h, addr,
                        i2, earIn, kbdIn, expDout, name);
            waitForBeam(f, l, h);
            portRead(addr, i2, earIn, kbdIn, expDout, name);
         end else if (tag == "X") begin
            n = $sscanf(lineBuf, "%s %d %d %d %s", tag, f, l, h, name);
            checkPixel(f, l, h, name);
         end else begin
            errors++;
            $display("Unknown record type %0s in the stimulus file", tag);
         end
      end
   endtask

   initial begin
      runCycles = 0;
      while (runCycles < timeoutCycles) begin
         @(posedge clkregs);
         runCycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("** FAIL **");
      $finish;
   end

   initial begin : mainFlow
      int fd;
      rst_n          = 1'b0;
      a              = 16'hFFFF;
      iorq_n         = 1'b1;
      rd_n           = 1'b1;
      wr_n           = 1'b1;
      din            = 8'h00;
      ear            = 1'b0;
      kbd            = 5'h1F;
      issue2Keyboard = 1'b0;
      // Red border out of reset
      borderModel    = 3'b010;
      micModel       = 1'b0;
      spkModel       = 1'b0;
      checks         = 0;
      errors         = 0;
      fillVram();
      repeat (16) @(negedge clkregs);
      rst_n = 1'b1;
      fd = $fopen("dv/ulaInput.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open dv/ulaInput.txt");
      end else begin
         runRecords(fd);
         $fclose(fd);
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* rtl/beamCounter.sv */
`timescale 1ns/1ps

module beamCounter
   import ulaPkg::*;
(
   input logic   clkregs,
   input logic   rst_n,
   beamIf.source beam
);

   hcount_t hcCnt;
   vcount_t vcCnt;
   logic    lineEnd;

   assign lineEnd = (hcCnt == hcount_t'(lineClocks - 1));

   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         hcCnt <= '0;
         vcCnt <= '0;
      end else begin
         hcCnt <= lineEnd ? '0 : hcCnt + 1'b1;
         if (lineEnd) begin
            vcCnt <= (vcCnt == vcount_t'(frameLines - 1)) ? '0 : vcCnt + 1'b1;
         end
      end
   end

   assign beam.hc = hcCnt;
   assign beam.vc = vcCnt;

   // Paper fetch covers 256 clocks starting at fetchStart
   assign beam.paperFetch = (hcCnt >= fetchStart) && (hcCnt < fetchStart + paperWidth) &&
                            (vcCnt < paperHeight);

   // Pixels reach the encoder one clock before they show
   assign beam.paperShow = (hcCnt >= pixelLatency - 1) &&
                           (hcCnt < pixelLatency - 1 + paperWidth) &&
                           (vcCnt < paperHeight);

   assign beam.frameTick = (vcCnt == vcount_t'(flashLine)) && (hcCnt == '0);

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   hcInRange: assert property (@(posedge clkregs) disable iff (!rst_n)
      hcCnt < lineClocks);

   vcInRange: assert property (@(posedge clkregs) disable iff (!rst_n)
      vcCnt < frameLines);

endmodule

/* rtl/beamIf.sv */
`timescale 1ns/1ps

interface beamIf
   import ulaPkg::*;
();

   // Beam position
   hcount_t hc;
   vcount_t vc;

   // Fetch window, and the same window as seen at the colour encoder input
   logic paperFetch;
   logic paperShow;

   // One clock per frame, at the start of flashLine
   logic frameTick;

   modport source (
      output hc, vc, paperFetch, paperShow, frameTick
   );

   modport sink (
      input hc, vc, paperFetch, paperShow, frameTick
   );

endinterface

/* rtl/colourEncoder.sv */
`timescale 1ns/1ps

module colourEncoder
   import ulaPkg::*;
(
   input  logic       clkregs,
   input  logic       rst_n,
   input  igrb_t      pixelIgrb,
   input  logic       pixelPaper,
   input  logic [2:0] border,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b
);

   igrb_t colourSel;
   rgb9_t rgbNext;
   rgb9_t rgbReg;

   // One channel of the standard palette
   function automatic logic [2:0] channelLevel(input logic on, input logic bright);
      logic [2:0] level;
      if (!on) begin
         level = levelNone;
      end else if (bright) begin
         level = levelFull;
      end else begin
         level = levelHalf;
      end
      return level;
   endfunction

   // Border is never bright
   always_comb begin
      if (pixelPaper) begin
         colourSel = pixelIgrb;
      end else begin
         colourSel = {1'b0, border};
      end
   end

   always_comb begin
      rgbNext.g = channelLevel(colourSel.green, colourSel.bright);
      rgbNext.r = channelLevel(colourSel.red, colourSel.bright);
      rgbNext.b = channelLevel(colourSel.blue, colourSel.bright);
   end

   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         rgbReg <= '0;
      end else begin
         rgbReg <= rgbNext;
      end
   end

   assign r = rgbReg.r;
   assign g = rgbReg.g;
   assign b = rgbReg.b;

endmodule

/* rtl/cpuPort.sv */
`timescale 1ns/1ps

module cpuPort
   import ulaPkg::*;
(
   input  logic        clkregs,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   input  logic        ear,
   input  logic [4:0]  kbd,
   input  logic        issue2Keyboard,
   output logic [2:0]  border,
   output logic        mic,
   output logic        spk
);

   typedef enum logic [1:0] {
      busIdle,
      busWriteFe,
      busReadFe
   } feAccess_e;

   feAccess_e access;
   logic      feSelected;
   logic      earBit;

   assign feSelected = !iorq_n && ((a & portFeMask) == '0);

   always_comb begin
      access = busIdle;
      if (feSelected && !wr_n) begin
         access = busWriteFe;
      end else if (feSelected && !rd_n) begin
         access = busReadFe;
      end
   end

   // Port FE outputs
   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         border <= borderReset;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (access == busWriteFe) begin
         border <= din[2:0];
         mic    <= din[3];
         spk    <= din[4];
      end
   end

   // Issue 2 boards also see MIC on the EAR input
   assign earBit = issue2Keyboard ? (ear ^ (spk | mic)) : (ear ^ spk);

   always_comb begin
      case (access)
         busReadFe: dout = {1'b1, earBit, 1'b1, kbd};
         default:   dout = 8'hFF;
      endcase
   end

endmodule

/* rtl/pixelShifter.sv */
`timescale 1ns/1ps

module pixelShifter
   import ulaPkg::*;
(
   input  logic       clkregs,
   input  logic       rst_n,
   beamIf.sink        beam,
   input  logic       cellStrobe,
   input  logic [7:0] bitmapByte,
   input  logic [7:0] attrByte,
   input  logic       paperCell,
   output igrb_t      pixelIgrb,
   output logic       pixelPaper
);

   logic [7:0] shiftReg;
   logic [7:0] attrReg;
   logic       cellPaper;
   logic [4:0] flashCnt;
   logic       flashPhase;
   logic       pixelBit;

   ////////////////////////////////////////////////////////////////////////////
   // Serializer
   ////////////////////////////////////////////////////////////////////////////

   // MSB is the leftmost pixel of the cell
   always_ff @(posedge clkregs) begin
      if (cellStrobe) begin
         shiftReg <= bitmapByte;
         attrReg  <= attrByte;
      end else begin
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         cellPaper <= 1'b0;
      end else if (cellStrobe) begin
         cellPaper <= paperCell;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Flash
   ////////////////////////////////////////////////////////////////////////////

   // Phase toggles every 16 frames
   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         flashCnt <= '0;
      end else if (beam.frameTick) begin
         flashCnt <= flashCnt + 1'b1;
      end
   end

   assign flashPhase = flashCnt[4];

   // Attribute bit 7 swaps ink and paper while the phase is high
   assign pixelBit = shiftReg[7] ^ (attrReg[7] & flashPhase);

   always_comb begin
      pixelIgrb.bright = attrReg[6];
      if (pixelBit) begin
         {pixelIgrb.green, pixelIgrb.red, pixelIgrb.blue} = attrReg[2:0];
      end else begin
         {pixelIgrb.green, pixelIgrb.red, pixelIgrb.blue} = attrReg[5:3];
      end
   end

   assign pixelPaper = beam.paperShow && cellPaper;

endmodule

/* rtl/ulaPkg.sv */
package ulaPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Frame geometry, 48K timing
   ////////////////////////////////////////////////////////////////////////////

   localparam int lineClocks  = 448;
   localparam int frameLines  = 312;
   localparam int paperWidth  = 256;
   localparam int paperHeight = 192;

   // First hc of the fetch window
   localparam int fetchStart = 8;

   // Clocks from hc == x to pixel x on the RGB outputs
   localparam int pixelLatency = 14;

   // Line on which the flash counter advances
   localparam int flashLine = 248;

   typedef logic [8:0]  hcount_t;
   typedef logic [8:0]  vcount_t;
   typedef logic [12:0] vramAddr_t;

   ////////////////////////////////////////////////////////////////////////////
   // Colour types
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic bright;
      logic green;
      logic red;
      logic blue;
   } igrb_t;

   // GGGRRRBBB
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgb9_t;

   localparam logic [2:0] levelNone = 3'b000;
   localparam logic [2:0] levelHalf = 3'b101;
   localparam logic [2:0] levelFull = 3'b111;

   // Fetch slots within a character cell, values 5..7 are idle
   typedef enum logic [2:0] {
      phaseBitmapAddr = 3'd0,
      phaseBitmapLoad = 3'd1,
      phaseAttrAddr   = 3'd2,
      phaseAttrLoad   = 3'd3,
      phaseCellLoad   = 3'd4
   } fetchPhase_e;

   ////////////////////////////////////////////////////////////////////////////
   // CPU port
   ////////////////////////////////////////////////////////////////////////////

   // Port FE is any I/O address with A0 low
   localparam logic [15:0] portFeMask  = 16'h0001;
   localparam logic [2:0]  borderReset = 3'b010;

endpackage

/* rtl/ulaTop.sv */
`timescale 1ns/1ps

module ulaTop
   import ulaPkg::*;
(
   input  logic        clkregs,
   input  logic        rst_n,
   // CPU side
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   // I/O lines
   input  logic        ear,
   input  logic [4:0]  kbd,
   input  logic        issue2Keyboard,
   output logic        mic,
   output logic        spk,
   // VRAM
   output vramAddr_t   va,
   input  logic [7:0]  vramData,
   // Video
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b
);

   logic       cellStrobe;
   logic [7:0] bitmapByte;
   logic [7:0] attrByte;
   logic       paperCell;
   igrb_t      pixelIgrb;
   logic       pixelPaper;
   logic [2:0] border;

   beamIf beam ();

   beamCounter u_beamCounter (
      .clkregs (clkregs),
      .rst_n   (rst_n),
      .beam    (beam.source)
   );

   videoFetch u_videoFetch (
      .clkregs    (clkregs),
      .rst_n      (rst_n),
      .beam       (beam.sink),
      .va         (va),
      .vramData   (vramData),
      .cellStrobe (cellStrobe),
      .bitmapByte (bitmapByte),
      .attrByte   (attrByte),
      .paperCell  (paperCell)
   );

   pixelShifter u_pixelShifter (
      .clkregs    (clkregs),
      .rst_n      (rst_n),
      .beam       (beam.sink),
      .cellStrobe (cellStrobe),
      .bitmapByte (bitmapByte),
      .attrByte   (attrByte),
      .paperCell  (paperCell),
      .pixelIgrb  (pixelIgrb),
      .pixelPaper (pixelPaper)
   );

   colourEncoder u_colourEncoder (
      .clkregs    (clkregs),
      .rst_n      (rst_n),
      .pixelIgrb  (pixelIgrb),
      .pixelPaper (pixelPaper),
      .border     (border),
      .r          (r),
      .g          (g),
      .b          (b)
   );

   cpuPort u_cpuPort (
      .clkregs        (clkregs),
      .rst_n          (rst_n),
      .a              (a),
      .iorq_n         (iorq_n),
      .rd_n           (rd_n),
      .wr_n           (wr_n),
      .din            (din),
      .dout           (dout),
      .ear            (ear),
      .kbd            (kbd),
      .issue2Keyboard (issue2Keyboard),
      .border         (border),
      .mic            (mic),
      .spk            (spk)
   );

endmodule

/* rtl/videoFetch.sv */
`timescale 1ns/1ps

module videoFetch
   import ulaPkg::*;
(
   input  logic       clkregs,
   input  logic       rst_n,
   beamIf.sink        beam,
   output vramAddr_t  va,
   input  logic [7:0] vramData,
   output logic       cellStrobe,
   output logic [7:0] bitmapByte,
   output logic [7:0] attrByte,
   output logic       paperCell
);

   fetchPhase_e phase;
   hcount_t     colOffset;
   logic [4:0]  column;
   vramAddr_t   bitmapAddr;
   vramAddr_t   attrAddr;

   assign phase     = fetchPhase_e'(beam.hc[2:0]);
   assign colOffset = beam.hc - hcount_t'(fetchStart);
   assign column    = colOffset[7:3];

   ////////////////////////////////////////////////////////////////////////////
   // Screen address layout
   ////////////////////////////////////////////////////////////////////////////

   // Thirds, pixel row in char, char row, then column
   assign bitmapAddr = {beam.vc[7:6], beam.vc[2:0], beam.vc[5:3], column};

   // Attributes live at 0x1800 upward, one byte per cell
   assign attrAddr = {3'b110, beam.vc[7:3], column};

   always_comb begin
      case (phase)
         phaseBitmapAddr,
         phaseBitmapLoad: va = bitmapAddr;
         phaseAttrAddr,
         phaseAttrLoad:   va = beam.paperFetch ? attrAddr : bitmapAddr;
         default:         va = bitmapAddr;
      endcase
   end

   // Byte latches
   always_ff @(posedge clkregs) begin
      if (beam.paperFetch && phase == phaseBitmapLoad) begin
         bitmapByte <= vramData;
      end
      if (beam.paperFetch && phase == phaseAttrLoad) begin
         attrByte <= vramData;
      end
   end

   // Marks the latched pair as paper data
   always_ff @(posedge clkregs) begin
      if (!rst_n) begin
         paperCell <= 1'b0;
      end else if (phase == phaseAttrLoad) begin
         paperCell <= beam.paperFetch;
      end
   end

   assign cellStrobe = beam.paperFetch && (phase == phaseCellLoad);

   // Strobe only ever follows a complete fetch of the same cell
   strobeInWindow: assert property (@(posedge clkregs) disable iff (!rst_n)
      cellStrobe |-> paperCell && $past(beam.paperFetch, 4));

endmodule
